// File: sources.f
+incdir+.
selen_pkg.sv
fetch_if.sv
dec_if.sv
core_fetch_port.sv
core_reg_file.sv
core_dec_s.sv
core_issue_port.sv
core_dec_top.sv
core_dec_assertions.sv
tb_core_dec.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core_dec
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed
FAIL_MSG  ?= Checks failed

BIN := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST)) selen_settings.svh

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	fi; \
	echo "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_core_dec.sv
`timescale 1ns/1ps
`include "selen_settings.svh"

module tb_core_dec;

	localparam int WAIT_LIMIT = 200;   // Cycles allowed per handshake wait

	logic                      clk;
	logic                      rst_n;
	logic                      flush;
	logic                      inst_req;
	logic [`SELEN_XLEN-1:0]    inst;
	logic [`SELEN_XLEN-1:0]    pc;
	logic                      inst_ack;
	logic                      wb_we;
	logic [`SELEN_RIDX_W-1:0]  wb_rd;
	logic [`SELEN_XLEN-1:0]    wb_data;
	logic                      exe_req;
	logic                      exe_ack;
	selen_pkg::alu_op_e        exe_alu_op;
	selen_pkg::br_cnd_e        exe_br_cnd;
	logic [`SELEN_XLEN-1:0]    exe_src1;
	logic [`SELEN_XLEN-1:0]    exe_src2;
	logic [`SELEN_XLEN-1:0]    exe_imm;
	logic [`SELEN_XLEN-1:0]    exe_pc;
	logic [`SELEN_RIDX_W-1:0]  exe_rd;
	logic                      exe_we;
	logic                      exe_mem_val;
	logic                      exe_mem_wr;
	selen_pkg::mem_size_e      exe_mem_size;
	selen_pkg::wb_sx_e         exe_wb_sx;
	selen_pkg::hazard_e        exe_hazard;
	logic                      exe_illegal;

	logic [`SELEN_XLEN-1:0]    reg_mirror [0:`SELEN_NREGS-1];   // Expected register contents
	logic [31:0]               lcg_state;
	logic [31:0]               pc_next;
	int                        n_checks;
	int                        n_errors;
	selen_pkg::dec_bundle_t    expected_q [$];   // Oldest first

	core_dec_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// --------------------------------------------------
	// Random numbers and instruction encoding
	// --------------------------------------------------
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [4:0] pick_reg();
		logic [31:0] rnd;
		rnd = next_rand();
		return rnd[20:16];   // Upper bits, the low ones repeat quickly
	endfunction

	function automatic logic [31:0] r_inst(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_inst(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_inst(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_inst(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_inst(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_inst(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// --------------------------------------------------
	// Reference decoder
	// --------------------------------------------------
	function automatic selen_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic bit30,
			input logic reg_form);
		case (f3)
			3'd0: return (reg_form && bit30) ? selen_pkg::ALU_SUB : selen_pkg::ALU_ADD;
			3'd1: return selen_pkg::ALU_SLL;
			3'd2: return selen_pkg::ALU_SLT;
			3'd3: return selen_pkg::ALU_SLTU;
			3'd4: return selen_pkg::ALU_XOR;
			3'd5: return bit30 ? selen_pkg::ALU_SRA : selen_pkg::ALU_SRL;
			3'd6: return selen_pkg::ALU_OR;
			default: return selen_pkg::ALU_AND;
		endcase
	endfunction

	function automatic selen_pkg::dec_bundle_t expect_bundle(input logic [31:0] ins,
			input logic [31:0] at_pc);
		selen_pkg::dec_bundle_t e;
		logic [2:0]             f3;
		logic [31:0]            i_imm;
		logic [31:0]            u_imm;
		f3       = ins[14:12];
		i_imm    = 32'($signed(ins[31:20]));
		u_imm    = {ins[31:12], 12'h000};
		e        = '0;
		e.alu_op = selen_pkg::ALU_NONE;
		e.br_cnd = selen_pkg::BR_NONE;
		e.wb_sx  = selen_pkg::WB_PASS;
		e.hazard = selen_pkg::HZ_OTHER;
		e.pc     = at_pc;
		e.rd     = ins[11:7];
		e.src1   = reg_mirror[ins[19:15]];
		e.src2   = reg_mirror[ins[24:20]];
		case (ins[6:0])
			7'b0110011: begin
				e.alu_op = arith_op(f3, ins[30], 1'b1);
				e.we     = 1'b1;
			end
			7'b0010011: begin
				e.alu_op = arith_op(f3, ins[30], 1'b0);
				e.imm    = i_imm;
				e.we     = 1'b1;
			end
			7'b0110111: begin   // LUI
				e.imm   = u_imm;
				e.we    = 1'b1;
				e.wb_sx = selen_pkg::WB_IMM;
			end
			7'b0010111: begin   // AUIPC
				e.alu_op = selen_pkg::ALU_ADD;
				e.imm    = u_imm;
				e.we     = 1'b1;
			end
			7'b1100011: begin
				e.imm    = 32'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
				e.hazard = selen_pkg::HZ_BRANCH;
				if (f3 == 3'b000)
					e.br_cnd = selen_pkg::BR_BEQ;
				else if (f3 == 3'b001)
					e.br_cnd = selen_pkg::BR_BNE;
				else if (f3[1])
					e.br_cnd = selen_pkg::BR_BLTU;
				else
					e.br_cnd = selen_pkg::BR_BLT;
				if (f3 == 3'b101 || f3 == 3'b111) begin   // Greater-or-equal forms
					e.src1 = reg_mirror[ins[24:20]];
					e.src2 = reg_mirror[ins[19:15]];
				end
			end
			7'b1101111: begin   // JAL
				e.imm    = 32'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
				e.we     = 1'b1;
				e.wb_sx  = selen_pkg::WB_PC;
				e.hazard = selen_pkg::HZ_JUMP;
			end
			7'b1100111: begin   // JALR
				e.alu_op = selen_pkg::ALU_ADD;
				e.imm    = i_imm;
				e.we     = 1'b1;
				e.wb_sx  = selen_pkg::WB_PC;
				e.hazard = selen_pkg::HZ_JUMP;
			end
			7'b0000011: begin
				e.alu_op   = selen_pkg::ALU_ADD;
				e.imm      = i_imm;
				e.we       = 1'b1;
				e.hazard   = selen_pkg::HZ_LOAD;
				e.mem_val  = 1'b1;
				e.mem_size = selen_pkg::mem_size_e'(f3[1:0]);
				case (f3)
					3'b000:  e.wb_sx = selen_pkg::WB_B;
					3'b001:  e.wb_sx = selen_pkg::WB_H;
					3'b100:  e.wb_sx = selen_pkg::WB_UB;
					3'b101:  e.wb_sx = selen_pkg::WB_UH;
					default: e.wb_sx = selen_pkg::WB_PASS;
				endcase
			end
			7'b0100011: begin
				e.alu_op   = selen_pkg::ALU_ADD;
				e.imm      = 32'($signed({ins[31:25], ins[11:7]}));
				e.mem_val  = 1'b1;
				e.mem_wr   = 1'b1;
				e.mem_size = selen_pkg::mem_size_e'(f3[1:0]);
			end
			default: e.illegal = 1'b1;
		endcase
		return e;
	endfunction

	// --------------------------------------------------
	// Checks and handshake models
	// --------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		n_checks++;
		assert (got === exp) else begin
			n_errors++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bundle(input selen_pkg::dec_bundle_t e);
		check_value("exe_illegal", 32'(exe_illegal), 32'(e.illegal));
		check_value("exe_we", 32'(exe_we), 32'(e.we));
		check_value("exe_mem_val", 32'(exe_mem_val), 32'(e.mem_val));
		check_value("exe_pc", exe_pc, e.pc);
		if (!e.illegal) begin   // A bubble carries nothing else of use
			check_value("exe_alu_op", 32'(exe_alu_op), 32'(e.alu_op));
			check_value("exe_br_cnd", 32'(exe_br_cnd), 32'(e.br_cnd));
			check_value("exe_src1", exe_src1, e.src1);
			check_value("exe_src2", exe_src2, e.src2);
			check_value("exe_imm", exe_imm, e.imm);
			check_value("exe_rd", 32'(exe_rd), 32'(e.rd));
			check_value("exe_mem_wr", 32'(exe_mem_wr), 32'(e.mem_wr));
			check_value("exe_wb_sx", 32'(exe_wb_sx), 32'(e.wb_sx));
			check_value("exe_hazard", 32'(exe_hazard), 32'(e.hazard));
			if (e.mem_val)
				check_value("exe_mem_size", 32'(exe_mem_size), 32'(e.mem_size));
		end
	endtask

	// Fetch source side of the four-phase handshake
	task automatic send_inst(input logic [31:0] ins, input logic [31:0] at_pc);
		int cycles;
		@(negedge clk);
		inst_req = 1'b1;
		inst     = ins;
		pc       = at_pc;
		cycles   = 0;
		while (!inst_ack && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		assert (inst_ack) else begin
			n_errors++;
			$display("Fetch of %h at pc %h was never acknowledged", ins, at_pc);
		end
		inst_req = 1'b0;
		cycles   = 0;
		while (inst_ack && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		assert (!inst_ack) else begin
			n_errors++;
			$display("inst_ack stayed high after inst_req dropped at pc %h", at_pc);
		end
	endtask

	task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
		@(negedge clk);
		wb_we   = 1'b1;
		wb_rd   = rd;
		wb_data = data;
		@(negedge clk);
		wb_we = 1'b0;
		if (rd != 5'd0)
			reg_mirror[rd] = data;
	endtask

	// Execute side, checks the bundle then completes the handshake
	task automatic take_issue(input selen_pkg::dec_bundle_t e);
		int cycles;
		cycles = 0;
		while (!exe_req && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		assert (exe_req) else begin
			n_errors++;
			$display("No exe_req arrived for the instruction at pc %h", e.pc);
		end
		if (exe_req) begin
			check_bundle(e);
			exe_ack = 1'b1;
			cycles  = 0;
			while (exe_req && cycles < WAIT_LIMIT) begin
				@(negedge clk);
				cycles++;
			end
			assert (!exe_req) else begin
				n_errors++;
				$display("exe_req stayed high after exe_ack at pc %h", e.pc);
			end
			exe_ack = 1'b0;
		end
	endtask

	task automatic decode_one(input logic [31:0] ins);
		selen_pkg::dec_bundle_t e;
		e = expect_bundle(ins, pc_next);
		send_inst(ins, pc_next);
		take_issue(e);
		pc_next += 32'd4;
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic reset_and_regs();
		logic [31:0] rnd;
		check_value("inst_ack", 32'(inst_ack), 32'd0);
		check_value("exe_req", 32'(exe_req), 32'd0);
		for (int r = 1; r < `SELEN_NREGS; r++) begin
			rnd = next_rand();
			write_reg(5'(r), rnd);
		end
		write_reg(5'd0, 32'hdead_beef);   // x0 keeps reading zero
		for (int k = 0; k < `SELEN_NREGS; k++)
			decode_one(r_inst(7'h00, 5'(31 - k), 5'(k), 3'b110, 5'(k)));
	endtask

	task automatic arith_ops();
		logic [31:0] rnd;
		logic [11:0] imm;
		for (int f = 0; f < 8; f++)
			decode_one(r_inst(7'h00, pick_reg(), pick_reg(), 3'(f), pick_reg()));
		decode_one(r_inst(7'h20, pick_reg(), pick_reg(), 3'b000, pick_reg()));   // SUB
		decode_one(r_inst(7'h20, pick_reg(), pick_reg(), 3'b101, pick_reg()));   // SRA
		for (int n = 0; n < 2; n++) begin
			for (int f = 0; f < 8; f++) begin
				rnd = next_rand();
				imm = rnd[11:0];
				if (f == 1)
					imm[11:5] = 7'h00;
				else if (f == 5)
					imm[11:5] = (n == 1) ? 7'h20 : 7'h00;
				decode_one(i_inst(imm, pick_reg(), 3'(f), pick_reg(), 7'b0010011));
			end
		end
	endtask

	task automatic control_flow();
		logic [31:0] rnd;
		logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		for (int k = 0; k < 6; k++) begin
			rnd = next_rand();
			decode_one(b_inst({rnd[12:1], 1'b0}, pick_reg(), pick_reg(), br_f3[k]));
		end
		decode_one(b_inst(13'h1ffc, 5'd3, 5'd4, 3'b101));   // BGE back by 4
		decode_one(b_inst(13'h0010, 5'd6, 5'd5, 3'b111));   // BGEU
		rnd = next_rand();
		decode_one(j_inst({rnd[20:1], 1'b0}, pick_reg()));
		rnd = next_rand();
		decode_one(i_inst(rnd[11:0], pick_reg(), 3'b000, pick_reg(), 7'b1100111));
		rnd = next_rand();
		decode_one(u_inst(rnd[31:12], pick_reg(), 7'b0110111));
		rnd = next_rand();
		decode_one(u_inst(rnd[31:12], pick_reg(), 7'b0010111));
	endtask

	task automatic memory_ops();
		logic [31:0] rnd;
		logic [2:0]  ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
		for (int k = 0; k < 5; k++) begin
			rnd = next_rand();
			decode_one(i_inst(rnd[11:0], pick_reg(), ld_f3[k], pick_reg(), 7'b0000011));
		end
		for (int f = 0; f < 3; f++) begin
			rnd = next_rand();
			decode_one(s_inst(rnd[11:0], pick_reg(), pick_reg(), 3'(f)));
		end
		decode_one({25'h1abcdef, 7'b1111011});   // Unknown opcodes
		decode_one(32'h0000_000f);
		decode_one(32'h0000_0000);
	endtask

	// Three in flight with exe_ack held off
	task automatic held_burst();
		logic [31:0] rnd;
		logic [31:0] ins;
		for (int k = 0; k < 3; k++) begin
			rnd = next_rand();
			ins = i_inst(rnd[11:0], 5'(k + 3), 3'b100, 5'(k + 10), 7'b0010011);
			expected_q.push_back(expect_bundle(ins, pc_next));
			send_inst(ins, pc_next);
			pc_next += 32'd4;
		end
		for (int k = 0; k < 3; k++)
			take_issue(expected_q.pop_front());
	endtask

	task automatic flush_buffered();
		logic [31:0]            rnd;
		logic [31:0]            ins;
		logic                   quiet;
		selen_pkg::dec_bundle_t first;
		for (int k = 0; k < 3; k++) begin
			rnd = next_rand();
			ins = r_inst(7'h00, pick_reg(), pick_reg(), rnd[2:0], 5'(k + 20));
			if (k == 0)
				first = expect_bundle(ins, pc_next);
			send_inst(ins, pc_next);
			pc_next += 32'd4;
		end
		@(negedge clk);
		flush = 1'b1;
		@(negedge clk);
		flush = 1'b0;
		take_issue(first);   // Already raised, so it completes
		quiet = 1'b1;
		repeat (30) begin
			@(negedge clk);
			if (exe_req)
				quiet = 1'b0;
		end
		assert (quiet) else begin
			n_errors++;
			$display("exe_req rose again for an instruction that was flushed");
		end
		decode_one(r_inst(7'h20, 5'd7, 5'd8, 3'b000, 5'd9));   // Pipe still works
	endtask

	initial begin
		rst_n     = 1'b0;
		flush     = 1'b0;
		inst_req  = 1'b0;
		inst      = '0;
		pc        = '0;
		wb_we     = 1'b0;
		wb_rd     = '0;
		wb_data   = '0;
		exe_ack   = 1'b0;
		lcg_state = 32'h9e675d68;
		pc_next   = 32'h0000_1000;
		n_checks  = 0;
		n_errors  = 0;
		for (int r = 0; r < `SELEN_NREGS; r++)
			reg_mirror[r] = '0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		reset_and_regs();
		arith_ops();
		control_flow();
		memory_ops();
		held_burst();
		flush_buffered();

		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: core_dec_assertions.sv
`timescale 1ns/1ps
`include "selen_settings.svh"

module core_dec_assertions (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      inst_req,
	input logic                      inst_ack,
	input logic                      exe_req,
	input logic                      exe_ack,
	input selen_pkg::alu_op_e        exe_alu_op,
	input selen_pkg::br_cnd_e        exe_br_cnd,
	input logic [`SELEN_XLEN-1:0]    exe_src1,
	input logic [`SELEN_XLEN-1:0]    exe_src2,
	input logic [`SELEN_XLEN-1:0]    exe_imm,
	input logic [`SELEN_XLEN-1:0]    exe_pc,
	input logic [`SELEN_RIDX_W-1:0]  exe_rd,
	input logic                      exe_we,
	input logic                      exe_mem_val,
	input logic                      exe_mem_wr,
	input selen_pkg::mem_size_e      exe_mem_size,
	input selen_pkg::wb_sx_e         exe_wb_sx,
	input selen_pkg::hazard_e        exe_hazard,
	input logic                      exe_illegal
);

	logic [$bits(selen_pkg::dec_bundle_t)-1:0] exe_fields;

	assign exe_fields = {exe_alu_op, exe_br_cnd, exe_src1, exe_src2, exe_imm, exe_pc, exe_rd,
		exe_we, exe_mem_val, exe_mem_wr, exe_mem_size, exe_wb_sx, exe_hazard, exe_illegal};

	// --------------------------------------------------
	// Four-phase ordering on both sides
	// --------------------------------------------------
	ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(inst_ack && inst_req) |=> inst_ack)
		else $error("inst_ack fell while inst_req was still high");

	req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(exe_req && !exe_ack) |=> exe_req)
		else $error("exe_req fell before exe_ack rose");

	// Bundle frozen from exe_req rise until exe_ack falls
	fields_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(exe_req || exe_ack) |=> $stable(exe_fields))
		else $error("exe_ fields changed during the execute handshake");

endmodule

bind core_dec_top core_dec_assertions hs_check_i (.*);

// File: core_dec_top.sv
`timescale 1ns/1ps
`include "selen_settings.svh"

module core_dec_top (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      flush,
	// Fetch side
	input  logic                      inst_req,
	input  logic [`SELEN_XLEN-1:0]    inst,
	input  logic [`SELEN_XLEN-1:0]    pc,
	output logic                      inst_ack,
	// Register writeback
	input  logic                      wb_we,
	input  logic [`SELEN_RIDX_W-1:0]  wb_rd,
	input  logic [`SELEN_XLEN-1:0]    wb_data,
	// Execute side
	output logic                      exe_req,
	input  logic                      exe_ack,
	output selen_pkg::alu_op_e        exe_alu_op,
	output selen_pkg::br_cnd_e        exe_br_cnd,
	output logic [`SELEN_XLEN-1:0]    exe_src1,
	output logic [`SELEN_XLEN-1:0]    exe_src2,
	output logic [`SELEN_XLEN-1:0]    exe_imm,
	output logic [`SELEN_XLEN-1:0]    exe_pc,
	output logic [`SELEN_RIDX_W-1:0]  exe_rd,
	output logic                      exe_we,
	output logic                      exe_mem_val,
	output logic                      exe_mem_wr,
	output selen_pkg::mem_size_e      exe_mem_size,
	output selen_pkg::wb_sx_e         exe_wb_sx,
	output selen_pkg::hazard_e        exe_hazard,
	output logic                      exe_illegal
);

	fetch_if fetch_bus ();
	dec_if   dec_bus ();

	core_fetch_port u_fetch_port (
		.clk      (clk),
		.rst_n    (rst_n),
		.flush    (flush),
		.inst_req (inst_req),
		.inst     (inst),
		.pc       (pc),
		.inst_ack (inst_ack),
		.fout     (fetch_bus)
	);

	core_dec_s u_dec_s (
		.clk     (clk),
		.rst_n   (rst_n),
		.flush   (flush),
		.fin     (fetch_bus),
		.dout    (dec_bus),
		.wb_we   (wb_we),
		.wb_rd   (wb_rd),
		.wb_data (wb_data)
	);

	core_issue_port u_issue_port (
		.clk          (clk),
		.rst_n        (rst_n),
		.din          (dec_bus),
		.exe_ack      (exe_ack),
		.exe_req      (exe_req),
		.exe_alu_op   (exe_alu_op),
		.exe_br_cnd   (exe_br_cnd),
		.exe_src1     (exe_src1),
		.exe_src2     (exe_src2),
		.exe_imm      (exe_imm),
		.exe_pc       (exe_pc),
		.exe_rd       (exe_rd),
		.exe_we       (exe_we),
		.exe_mem_val  (exe_mem_val),
		.exe_mem_wr   (exe_mem_wr),
		.exe_mem_size (exe_mem_size),
		.exe_wb_sx    (exe_wb_sx),
		.exe_hazard   (exe_hazard),
		.exe_illegal  (exe_illegal)
	);

endmodule

// File: core_issue_port.sv
`timescale 1ns/1ps
`include "selen_settings.svh"

module core_issue_port (
	input  logic                      clk,
	input  logic                      rst_n,
	dec_if.dst                        din,
	input  logic                      exe_ack,
	output logic                      exe_req,
	output selen_pkg::alu_op_e        exe_alu_op,
	output selen_pkg::br_cnd_e        exe_br_cnd,
	output logic [`SELEN_XLEN-1:0]    exe_src1,
	output logic [`SELEN_XLEN-1:0]    exe_src2,
	output logic [`SELEN_XLEN-1:0]    exe_imm,
	output logic [`SELEN_XLEN-1:0]    exe_pc,
	output logic [`SELEN_RIDX_W-1:0]  exe_rd,
	output logic                      exe_we,
	output logic                      exe_mem_val,
	output logic                      exe_mem_wr,
	output selen_pkg::mem_size_e      exe_mem_size,
	output selen_pkg::wb_sx_e         exe_wb_sx,
	output selen_pkg::hazard_e        exe_hazard,
	output logic                      exe_illegal
);

	typedef enum logic [1:0] {
		EMPTY,
		REQ,
		WAIT_DROP
	} state_e;

	state_e                  state;
	logic                    take;
	selen_pkg::dec_bundle_t  buf_q;

	assign din.ready = (state == EMPTY);
	assign take      = din.valid && din.ready;

	// Four-phase master toward execute
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= EMPTY;
		end else begin
			case (state)
				EMPTY:     if (take) state <= REQ;
				REQ:       if (exe_ack) state <= WAIT_DROP;
				WAIT_DROP: if (!exe_ack) state <= EMPTY;   // Buffer free again
				default:   state <= EMPTY;
			endcase
		end
	end

	// Loaded only while empty, so fields hold until ack falls
	always_ff @(posedge clk) begin
		if (take)
			buf_q <= din.bundle;
	end

	assign exe_req      = (state == REQ);
	assign exe_alu_op   = buf_q.alu_op;
	assign exe_br_cnd   = buf_q.br_cnd;
	assign exe_src1     = buf_q.src1;
	assign exe_src2     = buf_q.src2;
	assign exe_imm      = buf_q.imm;
	assign exe_pc       = buf_q.pc;
	assign exe_rd       = buf_q.rd;
	assign exe_we       = buf_q.we;
	assign exe_mem_val  = buf_q.mem_val;
	assign exe_mem_wr   = buf_q.mem_wr;
	assign exe_mem_size = buf_q.mem_size;
	assign exe_wb_sx    = buf_q.wb_sx;
	assign exe_hazard   = buf_q.hazard;
	assign exe_illegal  = buf_q.illegal;

endmodule

// File: core_dec_s.sv
`timescale 1ns/1ps
`include "selen_settings.svh"

module core_dec_s (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      flush,
	fetch_if.dst                      fin,
	dec_if.src                        dout,
	input  logic                      wb_we,
	input  logic [`SELEN_RIDX_W-1:0]  wb_rd,
	input  logic [`SELEN_XLEN-1:0]    wb_data
);

	selen_pkg::opcode_e      opcode;
	logic [2:0]              funct3;
	logic [6:0]              funct7;
	logic [`SELEN_XLEN-1:0]  imm_i;
	logic [`SELEN_XLEN-1:0]  imm_s;
	logic [`SELEN_XLEN-1:0]  imm_b;
	logic [`SELEN_XLEN-1:0]  imm_u;
	logic [`SELEN_XLEN-1:0]  imm_j;
	logic [`SELEN_XLEN-1:0]  src1;
	logic [`SELEN_XLEN-1:0]  src2;
	logic                    swap;
	logic                    take;
	logic                    out_valid;
	selen_pkg::dec_bundle_t  nxt;
	selen_pkg::dec_bundle_t  out_q;

	// Shared by R and I arithmetic where only R has SUB
	function automatic selen_pkg::alu_op_e alu_func(input logic [2:0] f3, input logic alt,
			input logic is_reg);
		case (f3)
			3'b000:  alu_func = (alt && is_reg) ? selen_pkg::ALU_SUB : selen_pkg::ALU_ADD;
			3'b001:  alu_func = selen_pkg::ALU_SLL;
			3'b010:  alu_func = selen_pkg::ALU_SLT;
			3'b011:  alu_func = selen_pkg::ALU_SLTU;
			3'b100:  alu_func = selen_pkg::ALU_XOR;
			3'b101:  alu_func = alt ? selen_pkg::ALU_SRA : selen_pkg::ALU_SRL;
			3'b110:  alu_func = selen_pkg::ALU_OR;
			default: alu_func = selen_pkg::ALU_AND;
		endcase
	endfunction

	assign opcode = selen_pkg::opcode_e'(fin.inst[6:0]);
	assign funct3 = fin.inst[14:12];
	assign funct7 = fin.inst[31:25];

	// --------------------------------------------------
	// Immediate forms
	// --------------------------------------------------
	assign imm_i = {{20{fin.inst[31]}}, fin.inst[31:20]};
	assign imm_s = {{20{fin.inst[31]}}, fin.inst[31:25], fin.inst[11:7]};
	assign imm_b = {{19{fin.inst[31]}}, fin.inst[31], fin.inst[7], fin.inst[30:25],
		fin.inst[11:8], 1'b0};
	assign imm_u = {fin.inst[31:12], 12'b0};
	assign imm_j = {{11{fin.inst[31]}}, fin.inst[31], fin.inst[19:12], fin.inst[20],
		fin.inst[30:21], 1'b0};

	core_reg_file u_reg_file (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1     (fin.inst[19:15]),
		.rs2     (fin.inst[24:20]),
		.swap    (swap),
		.wb_we   (wb_we),
		.wb_rd   (wb_rd),
		.wb_data (wb_data),
		.src1    (src1),
		.src2    (src2)
	);

	// --------------------------------------------------
	// Opcode and function decode
	// --------------------------------------------------
	always_comb begin
		nxt          = '0;
		nxt.alu_op   = selen_pkg::ALU_NONE;
		nxt.br_cnd   = selen_pkg::BR_NONE;
		nxt.mem_size = selen_pkg::MEM_WORD;
		nxt.wb_sx    = selen_pkg::WB_PASS;
		nxt.hazard   = selen_pkg::HZ_OTHER;
		nxt.src1     = src1;
		nxt.src2     = src2;
		nxt.pc       = fin.pc;
		nxt.rd       = fin.inst[11:7];
		swap         = 1'b0;
		case (opcode)
			selen_pkg::OP_R: begin
				nxt.alu_op = alu_func(funct3, funct7[5], 1'b1);
				nxt.we     = 1'b1;
			end
			selen_pkg::OP_I_ARITH: begin
				nxt.alu_op = alu_func(funct3, funct7[5], 1'b0);
				nxt.imm    = imm_i;
				nxt.we     = 1'b1;
			end
			selen_pkg::OP_LUI: begin
				nxt.imm   = imm_u;
				nxt.we    = 1'b1;
				nxt.wb_sx = selen_pkg::WB_IMM;   // Result is the immediate itself
			end
			selen_pkg::OP_AUIPC: begin
				nxt.alu_op = selen_pkg::ALU_ADD;
				nxt.imm    = imm_u;
				nxt.we     = 1'b1;
			end
			selen_pkg::OP_BRANCH: begin
				nxt.imm    = imm_b;
				nxt.hazard = selen_pkg::HZ_BRANCH;
				swap       = funct3[2] && funct3[0];   // BGE, BGEU
				case (funct3)
					3'b000:         nxt.br_cnd = selen_pkg::BR_BEQ;
					3'b001:         nxt.br_cnd = selen_pkg::BR_BNE;
					3'b100, 3'b101: nxt.br_cnd = selen_pkg::BR_BLT;
					3'b110, 3'b111: nxt.br_cnd = selen_pkg::BR_BLTU;
					default:        nxt.br_cnd = selen_pkg::BR_NONE;
				endcase
			end
			selen_pkg::OP_JAL: begin
				nxt.imm    = imm_j;
				nxt.we     = 1'b1;
				nxt.wb_sx  = selen_pkg::WB_PC;   // Link address
				nxt.hazard = selen_pkg::HZ_JUMP;
			end
			selen_pkg::OP_JALR: begin
				nxt.alu_op = selen_pkg::ALU_ADD;
				nxt.imm    = imm_i;
				nxt.we     = 1'b1;
				nxt.wb_sx  = selen_pkg::WB_PC;
				nxt.hazard = selen_pkg::HZ_JUMP;
			end
			selen_pkg::OP_LOAD: begin
				nxt.alu_op  = selen_pkg::ALU_ADD;
				nxt.imm     = imm_i;
				nxt.we      = 1'b1;
				nxt.hazard  = selen_pkg::HZ_LOAD;
				nxt.mem_val = 1'b1;
				case (funct3)
					3'b000: begin
						nxt.mem_size = selen_pkg::MEM_BYTE;
						nxt.wb_sx    = selen_pkg::WB_B;
					end
					3'b001: begin
						nxt.mem_size = selen_pkg::MEM_HALF;
						nxt.wb_sx    = selen_pkg::WB_H;
					end
					3'b010: begin
						nxt.mem_size = selen_pkg::MEM_WORD;
						nxt.wb_sx    = selen_pkg::WB_PASS;
					end
					3'b100: begin
						nxt.mem_size = selen_pkg::MEM_BYTE;
						nxt.wb_sx    = selen_pkg::WB_UB;
					end
					3'b101: begin
						nxt.mem_size = selen_pkg::MEM_HALF;
						nxt.wb_sx    = selen_pkg::WB_UH;
					end
					default: nxt.mem_val = 1'b0;
				endcase
			end
			selen_pkg::OP_STORE: begin
				nxt.alu_op  = selen_pkg::ALU_ADD;
				nxt.imm     = imm_s;
				nxt.mem_val = 1'b1;
				nxt.mem_wr  = 1'b1;
				case (funct3)
					3'b000:  nxt.mem_size = selen_pkg::MEM_BYTE;
					3'b001:  nxt.mem_size = selen_pkg::MEM_HALF;
					3'b010:  nxt.mem_size = selen_pkg::MEM_WORD;
					default: nxt.mem_val  = 1'b0;
				endcase
			end
			// Unknown opcode goes on as a bubble with we and mem_val off
			default: nxt.illegal = 1'b1;
		endcase
	end

	// --------------------------------------------------
	// Output register
	// --------------------------------------------------
	assign fin.ready = !out_valid || dout.ready;
	assign take      = fin.valid && fin.ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (flush)
			out_valid <= 1'b0;   // Also drops an instruction arriving now
		else if (take)
			out_valid <= 1'b1;
		else if (dout.valid && dout.ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take)
			out_q <= nxt;
	end

	// Nothing moves to issue during flush
	assign dout.valid  = out_valid && !flush;
	assign dout.bundle = out_q;

endmodule

// File: core_reg_file.sv
`timescale 1ns/1ps
`include "selen_settings.svh"

module core_reg_file (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`SELEN_RIDX_W-1:0]  rs1,
	input  logic [`SELEN_RIDX_W-1:0]  rs2,
	input  logic                      swap,
	input  logic                      wb_we,
	input  logic [`SELEN_RIDX_W-1:0]  wb_rd,
	input  logic [`SELEN_XLEN-1:0]    wb_data,
	output logic [`SELEN_XLEN-1:0]    src1,
	output logic [`SELEN_XLEN-1:0]    src2
);

	logic [`SELEN_XLEN-1:0] regs [1:`SELEN_NREGS-1];   // x0 has no storage
	logic [`SELEN_XLEN-1:0] rd1;
	logic [`SELEN_XLEN-1:0] rd2;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `SELEN_NREGS; i++)
				regs[i] <= '0;
		end else if (wb_we && (wb_rd != '0)) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// No write bypass, a write shows up one cycle later
	assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

	// Swapped order carries BGE and BGEU
	assign src1 = swap ? rd2 : rd1;
	assign src2 = swap ? rd1 : rd2;

endmodule

// File: core_fetch_port.sv
`timescale 1ns/1ps
`include "selen_settings.svh"

module core_fetch_port (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    flush,
	input  logic                    inst_req,
	input  logic [`SELEN_XLEN-1:0]  inst,
	input  logic [`SELEN_XLEN-1:0]  pc,
	output logic                    inst_ack,
	fetch_if.src                    fout
);

	typedef enum logic [1:0] {
		IDLE,
		ACK,
		WAIT_DROP
	} state_e;

	state_e                  state;
	logic                    take;       // Request captured this cycle
	logic                    buf_valid;
	logic [`SELEN_XLEN-1:0]  buf_inst;
	logic [`SELEN_XLEN-1:0]  buf_pc;

	// --------------------------------------------------
	// Four-phase slave toward the fetch source
	// --------------------------------------------------
	assign take = (state == IDLE) && inst_req && !buf_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:      if (take) state <= ACK;
				ACK:       state <= inst_req ? WAIT_DROP : IDLE;
				WAIT_DROP: if (!inst_req) state <= IDLE;   // ack falls with this
				default:   state <= IDLE;
			endcase
		end
	end

	assign inst_ack = (state != IDLE);

	// --------------------------------------------------
	// One-entry instruction buffer
	// --------------------------------------------------
	// A flushed capture still gets its ack, only the data is dropped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			buf_valid <= 1'b0;
		else if (flush)
			buf_valid <= 1'b0;
		else if (take)
			buf_valid <= 1'b1;
		else if (fout.valid && fout.ready)
			buf_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			buf_inst <= inst;
			buf_pc   <= pc;
		end
	end

	assign fout.valid = buf_valid;
	assign fout.inst  = buf_inst;
	assign fout.pc    = buf_pc;

endmodule

// File: dec_if.sv
`timescale 1ns/1ps

interface dec_if;

	logic                    valid;
	logic                    ready;
	selen_pkg::dec_bundle_t  bundle;

	// Decoder side
	modport src (
		output valid,
		output bundle,
		input  ready
	);

	// Issue port side
	modport dst (
		input  valid,
		input  bundle,
		output ready
	);

endinterface

// File: fetch_if.sv
`timescale 1ns/1ps
`include "selen_settings.svh"

interface fetch_if;

	logic                    valid;
	logic                    ready;
	logic [`SELEN_XLEN-1:0]  inst;
	logic [`SELEN_XLEN-1:0]  pc;     // Address of inst

	// Fetch port side
	modport src (
		output valid,
		output inst,
		output pc,
		input  ready
	);

	// Decoder side
	modport dst (
		input  valid,
		input  inst,
		input  pc,
		output ready
	);

endinterface

// File: selen_pkg.sv
`include "selen_settings.svh"

package selen_pkg;

	// RV32I major opcodes handled by the decoder
	typedef enum logic [6:0] {
		OP_R       = 7'b0110011,
		OP_I_ARITH = 7'b0010011,
		OP_LUI     = 7'b0110111,
		OP_AUIPC   = 7'b0010111,
		OP_BRANCH  = 7'b1100011,
		OP_JAL     = 7'b1101111,
		OP_JALR    = 7'b1100111,
		OP_LOAD    = 7'b0000011,
		OP_STORE   = 7'b0100011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLT  = 4'd2,
		ALU_SLTU = 4'd3,
		ALU_AND  = 4'd4,
		ALU_OR   = 4'd5,
		ALU_XOR  = 4'd6,
		ALU_SLL  = 4'd7,
		ALU_SRL  = 4'd8,
		ALU_SRA  = 4'd9,
		ALU_NONE = 4'd15
	} alu_op_e;

	// BGE and BGEU travel as BLT and BLTU with swapped operands
	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_BEQ  = 3'd1,
		BR_BNE  = 3'd2,
		BR_BLT  = 3'd3,
		BR_BLTU = 3'd4
	} br_cnd_e;

	typedef enum logic [1:0] {
		HZ_OTHER  = 2'd0,
		HZ_BRANCH = 2'd1,
		HZ_JUMP   = 2'd2,
		HZ_LOAD   = 2'd3
	} hazard_e;

	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_size_e;

	typedef enum logic [2:0] {
		WB_PASS = 3'd0,
		WB_B    = 3'd1,
		WB_UB   = 3'd2,
		WB_H    = 3'd3,
		WB_UH   = 3'd4,
		WB_PC   = 3'd5,
		WB_IMM  = 3'd6
	} wb_sx_e;

	// One decoded instruction as handed to execute
	typedef struct packed {
		alu_op_e                   alu_op;
		br_cnd_e                   br_cnd;
		logic [`SELEN_XLEN-1:0]    src1;
		logic [`SELEN_XLEN-1:0]    src2;
		logic [`SELEN_XLEN-1:0]    imm;
		logic [`SELEN_XLEN-1:0]    pc;
		logic [`SELEN_RIDX_W-1:0]  rd;
		logic                      we;
		logic                      mem_val;
		logic                      mem_wr;     // 1 for store
		mem_size_e                 mem_size;
		wb_sx_e                    wb_sx;
		hazard_e                   hazard;
		logic                      illegal;
	} dec_bundle_t;

endpackage

// File: selen_settings.svh
`ifndef SELEN_SETTINGS_SVH
`define SELEN_SETTINGS_SVH

// --------------------------------------------------
// Core widths
// --------------------------------------------------

// One machine word
`define SELEN_XLEN 32

// Architectural registers, x0 included
`define SELEN_NREGS 32

// Register index field
`define SELEN_RIDX_W 5

`endif
